//--- design/reorderPkg.sv
/*
 * Shared sizes, field types and packed transfer structs for the read
 * reorder unit
 */

`default_nettype none

package reorderPkg;

    // Scoreboard depth; one slot stays unused so full and empty differ
    localparam int NUM_ENTRIES = 16;
    localparam int IDX_BITS = $clog2(NUM_ENTRIES);

    // Field widths of the client and memory transfers
    localparam int ADDR_BITS = 32;
    localparam int DATA_BITS = 64;
    localparam int TAG_BITS = 8;

    typedef logic [IDX_BITS-1:0] tIdx;
    typedef logic [ADDR_BITS-1:0] tAddr;
    typedef logic [DATA_BITS-1:0] tData;
    typedef logic [TAG_BITS-1:0] tTag;

    // Client read request as issued by the client
    typedef struct packed {
        tAddr addr;
        tTag tag;
    } tReadReq;

    // Memory request carries the scoreboard slot in place of the client tag
    typedef struct packed {
        tAddr addr;
        tIdx idx;
    } tMemReq;

    // Memory response comes back tagged with the same slot index
    typedef struct packed {
        tIdx idx;
        tData data;
    } tMemRsp;

    // Client response pairs the original tag with the read data
    typedef struct packed {
        tTag tag;
        tData data;
    } tReadRsp;

endpackage

`default_nettype wire

//--- design/dualPortRam.sv
/*
 * Scoreboard storage with one write port and one registered read port
 */

`default_nettype none

module dualPortRam
    import reorderPkg::*;
#(
    // Entry type so one RAM serves both data and tag storage
    parameter type tEntry = tData
)
(
    input  logic  clk,

    // Write port
    input  logic  wrEn,
    input  tIdx   wrAddr,
    input  tEntry wrEntry,

    // Read port with one cycle of latency
    input  tIdx   rdAddr,
    output tEntry rdEntry
);

    // One entry per scoreboard slot
    tEntry mem [NUM_ENTRIES];

    // Writes land at the clock edge
    always_ff @(posedge clk)
    begin
        if (wrEn)
        begin
            mem[wrAddr] <= wrEntry;
        end
    end

    // The read is registered and sees the array contents before any
    // write on the same edge
    always_ff @(posedge clk)
    begin
        rdEntry <= mem[rdAddr];
    end

endmodule

`default_nettype wire

//--- design/reorderScoreboard.sv
/*
 * Slot allocator and out-of-order sorter that hands back data and tag
 * in allocation order
 */

`default_nettype none

module reorderScoreboard
    import reorderPkg::*;
(
    input  logic   clk,
    input  logic   resetb,

    // Allocation side
    // The tag is stored as slot metadata at allocation time
    input  logic   allocEn,
    input  tTag    allocTag,
    output logic   notFull,
    output tIdx    allocIdx,

    // Memory responses arrive in any order and are always accepted
    input  logic   memRspEn,
    input  tMemRsp memRsp,

    // Ordered output side
    input  logic   deqEn,
    output logic   notEmpty,
    output tData   firstData,
    output tTag    firstTag
);

    // Empty when oldest equals newest and full when newest plus one
    // equals oldest
    tIdx newest;
    tIdx oldest;

    // Pointer to the entry that will be oldest after this edge
    tIdx oldestNext;

    // One bit per slot showing that its memory data has arrived
    logic [NUM_ENTRIES-1:0] slotValid;

    assign notFull = ((newest + tIdx'(1)) != oldest);

    // A new request always takes the slot at the newest pointer
    assign allocIdx = newest;

    assign oldestNext = oldest + (deqEn ? tIdx'(1) : tIdx'(0));

    // Advance the newest pointer for each allocation
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            newest <= '0;
        end
        else if (allocEn)
        begin
            newest <= newest + tIdx'(1);
        end
    end

    // Advance the oldest pointer for each dequeue
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            oldest <= '0;
        end
        else
        begin
            oldest <= oldestNext;
        end
    end

    // Data storage is written by memory responses at their own slot
    dualPortRam #(
        .tEntry (tData)
    ) i_dataRam (
        .clk     (clk),
        .wrEn    (memRspEn),
        .wrAddr  (memRsp.idx),
        .wrEntry (memRsp.data),
        .rdAddr  (oldestNext),
        .rdEntry (firstData)
    );

    // Tag storage is written when the slot is allocated
    dualPortRam #(
        .tEntry (tTag)
    ) i_tagRam (
        .clk     (clk),
        .wrEn    (allocEn),
        .wrAddr  (allocIdx),
        .wrEntry (allocTag),
        .rdAddr  (oldestNext),
        .rdEntry (firstTag)
    );

    // Slot valid bits
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            slotValid <= '0;
        end
        else
        begin
            // The dequeued slot becomes free for the next allocation
            if (deqEn)
            begin
                slotValid[oldest] <= 1'b0;
            end

            // Data arrival marks the slot ready for delivery
            if (memRspEn)
            begin
                slotValid[memRsp.idx] <= 1'b1;
            end
        end
    end

    // Registered at the next-oldest pointer so it lines up with the RAM
    // outputs, which read the same address on the same edge
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            notEmpty <= 1'b0;
        end
        else
        begin
            notEmpty <= slotValid[oldestNext];
        end
    end

endmodule

`default_nettype wire

//--- design/requestIssue.sv
/*
 * Input side that accepts client reads, allocates scoreboard slots and
 * issues the registered memory request
 */

`default_nettype none

module requestIssue
    import reorderPkg::*;
(
    input  logic    clk,
    input  logic    resetb,

    // Client request side
    input  logic    reqEn,
    input  tReadReq readReq,
    output logic    reqReady,

    // Slot allocation in the scoreboard
    output logic    allocEn,
    output tTag     allocTag,
    input  logic    notFull,
    input  tIdx     allocIdx,

    // Memory request side, which never stalls
    output logic    memReqEn,
    output tMemReq  memReq
);

    // Requests are accepted whenever a free slot exists
    assign reqReady = notFull;

    // Guard the allocation with notFull so a stray strobe cannot
    // overrun the scoreboard
    assign allocEn = reqEn && notFull;

    // The client tag rides along in the scoreboard as slot metadata
    assign allocTag = readReq.tag;

    // Memory request strobe lasts one cycle per accepted request
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            memReqEn <= 1'b0;
        end
        else
        begin
            memReqEn <= allocEn;
        end
    end

    // The slot index replaces the tag so responses can be sorted
    always_ff @(posedge clk)
    begin
        if (allocEn)
        begin
            memReq.addr <= readReq.addr;
            memReq.idx <= allocIdx;
        end
    end

endmodule

`default_nettype wire

//--- design/responseDeliver.sv
/*
 * Output side that drains the scoreboard into a one-entry client
 * response register held under back-pressure
 */

`default_nettype none

module responseDeliver
    import reorderPkg::*;
(
    input  logic    clk,
    input  logic    resetb,

    // Oldest scoreboard entry
    input  logic    notEmpty,
    input  tData    firstData,
    input  tTag     firstTag,
    output logic    deqEn,

    // Client response side
    input  logic    rspReady,
    output logic    rspValid,
    output tReadRsp readRsp
);

    // Dequeue when the oldest entry is ready and the output register is
    // either empty or handing its response over on this edge
    assign deqEn = notEmpty && (!rspValid || rspReady);

    // Output register occupancy
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            rspValid <= 1'b0;
        end
        else if (deqEn)
        begin
            rspValid <= 1'b1;
        end
        else if (rspReady)
        begin
            // Transfer with nothing behind it empties the register
            rspValid <= 1'b0;
        end
    end

    // Payload only changes on a dequeue, so it holds while stalled
    always_ff @(posedge clk)
    begin
        if (deqEn)
        begin
            readRsp.tag <= firstTag;
            readRsp.data <= firstData;
        end
    end

endmodule

`default_nettype wire

//--- design/readReorder.sv
/*
 * Read-response reorder unit top level
 * Connects the request issuer, the scoreboard and the response deliverer
 */

`default_nettype none

module readReorder
    import reorderPkg::*;
(
    input  logic    clk,
    input  logic    resetb,

    // Client requests
    input  logic    reqEn,
    input  tReadReq readReq,
    output logic    reqReady,

    // Memory requests and out-of-order responses
    output logic    memReqEn,
    output tMemReq  memReq,
    input  logic    memRspEn,
    input  tMemRsp  memRsp,

    // In-order client responses
    input  logic    rspReady,
    output logic    rspValid,
    output tReadRsp readRsp
);

    // Allocation between issuer and scoreboard
    logic allocEn;
    tTag allocTag;
    logic notFull;
    tIdx allocIdx;

    // Ordered drain between scoreboard and deliverer
    logic notEmpty;
    tData firstData;
    tTag firstTag;
    logic deqEn;

    requestIssue i_requestIssue (
        .clk      (clk),
        .resetb   (resetb),
        .reqEn    (reqEn),
        .readReq  (readReq),
        .reqReady (reqReady),
        .allocEn  (allocEn),
        .allocTag (allocTag),
        .notFull  (notFull),
        .allocIdx (allocIdx),
        .memReqEn (memReqEn),
        .memReq   (memReq)
    );

    reorderScoreboard i_reorderScoreboard (
        .clk       (clk),
        .resetb    (resetb),
        .allocEn   (allocEn),
        .allocTag  (allocTag),
        .notFull   (notFull),
        .allocIdx  (allocIdx),
        .memRspEn  (memRspEn),
        .memRsp    (memRsp),
        .deqEn     (deqEn),
        .notEmpty  (notEmpty),
        .firstData (firstData),
        .firstTag  (firstTag)
    );

    responseDeliver i_responseDeliver (
        .clk       (clk),
        .resetb    (resetb),
        .notEmpty  (notEmpty),
        .firstData (firstData),
        .firstTag  (firstTag),
        .deqEn     (deqEn),
        .rspReady  (rspReady),
        .rspValid  (rspValid),
        .readRsp   (readRsp)
    );

endmodule

`default_nettype wire

//--- verification/readReorder_asserts.sv
/*
 * Protocol assertions for the read reorder top level, attached by bind
 */

`default_nettype none

module readReorderAsserts
    import reorderPkg::*;
(
    input logic    clk,
    input logic    resetb,
    input logic    reqEn,
    input logic    reqReady,
    input logic    memReqEn,
    input logic    rspReady,
    input logic    rspValid,
    input logic    deqEn,
    input tReadRsp readRsp
);

    // Number of assertion failures, read by the testbench for its verdict
    int failCount = 0;

    // The client may only strobe a request while a slot is free
    reqOnlyWhenReady: assert property (@(posedge clk) disable iff (!resetb)
        reqEn |-> reqReady)
        else begin
            $error("reqEn was high while reqReady was low");
            failCount++;
        end

    // Each memory request strobe lasts a single cycle unless a new request
    // was accepted on the same edge
    memReqOneCycle: assert property (@(posedge clk) disable iff (!resetb)
        memReqEn && !(reqEn && reqReady) |=> !memReqEn)
        else begin
            $error("memReqEn stayed high without a newly accepted request");
            failCount++;
        end

    // A stalled response holds its payload and its valid level
    rspHoldStable: assert property (@(posedge clk) disable iff (!resetb)
        rspValid && !rspReady |=> rspValid && $stable(readRsp))
        else begin
            $error("readRsp or rspValid changed while the client stalled");
            failCount++;
        end

    // Idle outputs in the cycle after a reset edge
    resetIdle: assert property (@(posedge clk)
        !resetb |=> !memReqEn && !rspValid && !deqEn && reqReady)
        else begin
            $error("Outputs were not idle in the cycle after reset");
            failCount++;
        end

endmodule

bind readReorder readReorderAsserts i_readReorderAsserts (
    .clk      (clk),
    .resetb   (resetb),
    .reqEn    (reqEn),
    .reqReady (reqReady),
    .memReqEn (memReqEn),
    .rspReady (rspReady),
    .rspValid (rspValid),
    .deqEn    (deqEn),
    .readRsp  (readRsp)
);

`default_nettype wire

//--- verification/readReorderTb.sv
/*
 * Testbench for the read reorder unit with an out-of-order memory model,
 * the expected-order queue, response checks, watchdog and report
 */

`default_nettype none

module readReorderTb
    import reorderPkg::*;
();

    localparam int HALF_PERIOD = 50;
    localparam int DRIVE_DELAY = 10;
    localparam int RESET_CYCLES = 5;
    localparam int SEED = 32'h709f82c9;

    // Test lengths in requests; the watchdog allows 2000 cycles for each
    localparam int TEST_LENGTHS = 1 + 8 + 16 + 15 + 40 + 400;
    localparam int WATCHDOG_CYCLES = TEST_LENGTHS * 2000;

    // Longest wait for memory and the client to settle at the end of a test
    localparam int DRAIN_CYCLES = 1000;

    // Memory return orders and client ready patterns
    localparam int ORDER_IN = 0;
    localparam int ORDER_REVERSE = 1;
    localparam int ORDER_RANDOM = 2;
    localparam int READY_ALWAYS = 0;
    localparam int READY_RANDOM = 1;
    localparam int READY_STRETCH = 2;
    localparam int NO_LIMIT = 1000000;

    logic clk = 1'b0;
    logic resetb = 1'b0;
    logic reqEn = 1'b0;
    tReadReq readReq = '0;
    logic reqReady;
    logic memReqEn;
    tMemReq memReq;
    logic memRspEn = 1'b0;
    tMemRsp memRsp = '0;
    logic rspReady = 1'b0;
    logic rspValid;
    tReadRsp readRsp;

    // Expected client order and the memory model's outstanding requests
    tTag expTag [$];
    tAddr expAddr [$];
    tIdx pendIdx [$];
    tAddr pendAddr [$];

    int errorCount = 0;
    int checkCount = 0;
    int testCount = 0;
    tTag nextTag = '0;

    // Memory model and client ready controls set by the tests
    int memCredits = 0;
    int memOrder = ORDER_IN;
    int memPct = 100;
    int readyMode = READY_ALWAYS;
    int readyPct = 100;
    int stretchLeft = 0;
    logic stretchLevel = 1'b1;

    readReorder i_readReorder (
        .clk      (clk),
        .resetb   (resetb),
        .reqEn    (reqEn),
        .readReq  (readReq),
        .reqReady (reqReady),
        .memReqEn (memReqEn),
        .memReq   (memReq),
        .memRspEn (memRspEn),
        .memRsp   (memRsp),
        .rspReady (rspReady),
        .rspValid (rspValid),
        .readRsp  (readRsp)
    );

    always #HALF_PERIOD clk = ~clk;

    // Errors from the testbench checks and from the bound assertions
    function automatic int totalErrors();
        return errorCount + i_readReorder.i_readReorderAsserts.failCount;
    endfunction

    // Advance to the drive point of the next cycle
    task automatic stepCycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // One client read, strobed only once a slot is free
    task automatic issueRead(input tAddr addr);
        while (!reqReady)
        begin
            stepCycle();
        end
        reqEn = 1'b1;
        readReq.addr = addr;
        readReq.tag = nextTag;
        nextTag++;
        stepCycle();
        reqEn = 1'b0;
    endtask

    task automatic issueBurst(input int count, input int maxGap);
        for (int i = 0; i < count; i++)
        begin
            issueRead($urandom());
            repeat ($urandom_range(maxGap, 0))
            begin
                stepCycle();
            end
        end
    endtask

    task automatic waitPending(input int count);
        while (pendIdx.size() < count)
        begin
            stepCycle();
        end
    endtask

    // Let memory and the client finish everything outstanding, then make
    // sure every request got exactly its response
    task automatic drainAll();
        int waited;
        waited = 0;
        while ((expTag.size() != 0 || pendIdx.size() != 0) && waited < DRAIN_CYCLES)
        begin
            stepCycle();
            waited++;
        end
        repeat (2)
        begin
            stepCycle();
        end
        assert (expTag.size() == 0 && pendIdx.size() == 0)
        else
        begin
            $display("Requests were still outstanding after memory and the client drained");
            errorCount++;
        end
    endtask

    // A batch of eight held back and then released in one order
    task automatic returnBatch(input int order);
        memCredits = 0;
        memOrder = order;
        issueBurst(8, 0);
        waitPending(8);
        memCredits = 8;
        drainAll();
    endtask

    task automatic finishTest(input string name, input int errStart);
        testCount++;
        $display("Test %0s finished with %0d error(s)", name, totalErrors() - errStart);
    endtask

    // Memory answers one pending request per cycle when it has credit
    always @(posedge clk)
    begin : memoryModel
        int pick;
        #DRIVE_DELAY;
        memRspEn = 1'b0;
        if (resetb && memCredits > 0 && pendIdx.size() > 0
            && $urandom_range(99, 0) < memPct)
        begin
            case (memOrder)
                ORDER_IN: pick = 0;
                ORDER_REVERSE: pick = pendIdx.size() - 1;
                default: pick = $urandom_range(pendIdx.size() - 1, 0);
            endcase
            // Read data is the address followed by its inverse
            memRsp.idx = pendIdx[pick];
            memRsp.data = {pendAddr[pick], ~pendAddr[pick]};
            pendIdx.delete(pick);
            pendAddr.delete(pick);
            memRspEn = 1'b1;
            memCredits--;
        end
    end

    // Client ready pattern, either steady, per cycle random or stretches
    always @(posedge clk)
    begin : clientReady
        #DRIVE_DELAY;
        case (readyMode)
            READY_ALWAYS: rspReady = 1'b1;
            READY_RANDOM: rspReady = ($urandom_range(99, 0) < readyPct);
            default:
            begin
                if (stretchLeft == 0)
                begin
                    stretchLevel = $urandom_range(1, 0);
                    stretchLeft = $urandom_range(8, 1);
                end
                rspReady = stretchLevel;
                stretchLeft--;
            end
        endcase
    end

    // Sampled mid-cycle where all inputs and registered outputs are stable
    always @(negedge clk)
    begin : responseCheck
        tTag wantTag;
        tAddr wantAddr;
        tData wantData;
        if (resetb && rspValid && rspReady)
        begin
            assert (expTag.size() > 0)
            else
            begin
                $display("A response with tag %h arrived with no request outstanding",
                    readRsp.tag);
                errorCount++;
            end
            if (expTag.size() > 0)
            begin
                wantTag = expTag.pop_front();
                wantAddr = expAddr.pop_front();
                wantData = {wantAddr, ~wantAddr};
                checkCount++;
                assert (readRsp.tag == wantTag && readRsp.data == wantData)
                else
                begin
                    $display("** Error (%0t): expected tag %h data %h, got tag %h data %h",
                        $time, wantTag, wantData, readRsp.tag, readRsp.data);
                    errorCount++;
                end
            end
        end
        if (resetb && reqEn && reqReady)
        begin
            expTag.push_back(readReq.tag);
            expAddr.push_back(readReq.addr);
        end
        if (resetb && memReqEn)
        begin
            pendIdx.push_back(memReq.idx);
            pendAddr.push_back(memReq.addr);
        end
    end

    initial
    begin : watchdog
        repeat (WATCHDOG_CYCLES)
        begin
            @(posedge clk);
        end
        $display("The run timed out after %0d cycles without finishing the tests",
            WATCHDOG_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial
    begin : mainFlow
        int errStart;
        void'($urandom(SEED));

        // Reset state
        repeat (RESET_CYCLES)
        begin
            @(posedge clk);
        end
        #DRIVE_DELAY;
        resetb = 1'b1;
        errStart = totalErrors();
        assert (reqReady === 1'b1 && rspValid === 1'b0 && memReqEn === 1'b0)
        else
        begin
            $display("Outputs were not idle at the end of reset");
            errorCount++;
        end
        finishTest("reset state", errStart);

        // In-order return
        errStart = totalErrors();
        memOrder = ORDER_IN;
        memCredits = NO_LIMIT;
        issueBurst(8, 0);
        drainAll();
        finishTest("in-order return", errStart);

        // Reverse, then shuffled return
        errStart = totalErrors();
        returnBatch(ORDER_REVERSE);
        returnBatch(ORDER_RANDOM);
        finishTest("reverse and shuffled return", errStart);

        // Fill all fifteen slots with memory withheld
        errStart = totalErrors();
        memCredits = 0;
        memOrder = ORDER_IN;
        issueBurst(15, 0);
        for (int i = 0; i < 5; i++)
        begin
            assert (!reqReady)
            else
            begin
                $display("reqReady was high with all slots outstanding");
                errorCount++;
            end
            stepCycle();
        end
        memCredits = 1;
        while (expTag.size() > 14)
        begin
            stepCycle();
        end
        for (int i = 0; i < 4 && !reqReady; i++)
        begin
            stepCycle();
        end
        assert (reqReady)
        else
        begin
            $display("reqReady did not rise after one response was delivered");
            errorCount++;
        end
        memCredits = NO_LIMIT;
        drainAll();
        finishTest("full scoreboard", errStart);

        // Client back-pressure in random stretches
        errStart = totalErrors();
        readyMode = READY_STRETCH;
        memOrder = ORDER_RANDOM;
        issueBurst(40, 2);
        drainAll();
        readyMode = READY_ALWAYS;
        finishTest("client back-pressure", errStart);

        // Random traffic on every interface
        errStart = totalErrors();
        readyMode = READY_RANDOM;
        readyPct = 70;
        memPct = 60;
        issueBurst(400, 3);
        drainAll();
        readyMode = READY_ALWAYS;
        finishTest("random traffic", errStart);

        $display("Tests run: %0d, responses checked: %0d, errors: %0d",
            testCount, checkCount, totalErrors());
        if (totalErrors() == 0)
        begin
            $display("SIMULATION PASSED");
        end
        else
        begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- readReorder.f
design/reorderPkg.sv
design/dualPortRam.sv
design/reorderScoreboard.sv
design/requestIssue.sv
design/responseDeliver.sv
design/readReorder.sv
verification/readReorder_asserts.sv
verification/readReorderTb.sv
